//--- Makefile
# Verilator build and run of the video_ycbcr_out testbench

VERILATOR ?= verilator
TOP       ?= tb_video_ycbcr_out
FILELIST  ?= video_ycbcr_out.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All tests passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verif/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --prefix V$(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Verdict comes from the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- design/rgb_to_ycbcr.sv
`timescale 1ns/10ps
`default_nettype none
/*
  RGB to YCbCr, three register stages, one pixel per clock.
  Results are floored by the arithmetic shift and clamped to 0..255.
  Pixels pass through whatever the state of de; blanking is masked later.
*/
module rgb_to_ycbcr (
  input  logic                    video_clk_148,
  input  logic                    video_reset_148,
  input  video_pkg::rgb_pixel_t   i_rgb,
  output video_pkg::ycbcr_pixel_t o_ycbcr
);
  import video_pkg::*;

  // Rows are Y, Cb, Cr and columns are R, G, B
  localparam int COEF [3][3] = '{
    '{COEF_YR,  COEF_YG,  COEF_YB},
    '{COEF_CBR, COEF_CBG, COEF_CBB},
    '{COEF_CRR, COEF_CRG, COEF_CRB}
  };

  logic        [COLOR_DEPTH-1:0] comp [3];
  logic signed [PROD_WIDTH-1:0]  prod [3][3];
  logic signed [SUM_WIDTH-1:0]   sum  [3];

  // Drop the fraction, add the chroma offset, saturate
  function automatic logic [COLOR_DEPTH-1:0] scale_clamp(
    input logic signed [SUM_WIDTH-1:0] s,
    input logic                        add_offset
  );
    logic signed [SUM_WIDTH-1:0] v;
    v = s >>> COEF_SHIFT;
    if (add_offset)
      v = v + SUM_WIDTH'(CHROMA_OFFSET);
    if (v < 0)
      return '0;
    else if (v > COMP_MAX)
      return '1;
    else
      return v[COLOR_DEPTH-1:0];
  endfunction

  assign comp[0] = i_rgb.r;
  assign comp[1] = i_rgb.g;
  assign comp[2] = i_rgb.b;

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      for (int i = 0; i < 3; i++)
      begin
        sum[i] <= '0;
        for (int j = 0; j < 3; j++)
          prod[i][j] <= '0;
      end
      o_ycbcr <= '0;
    end
    else
    begin
      // Stage 1, nine products
      for (int i = 0; i < 3; i++)
        for (int j = 0; j < 3; j++)
          prod[i][j] <= PROD_WIDTH'($signed({1'b0, comp[j]}) * COEF[i][j]);

      // Stage 2, row sums
      for (int i = 0; i < 3; i++)
        sum[i] <= SUM_WIDTH'(prod[i][0]) + SUM_WIDTH'(prod[i][1])
                  + SUM_WIDTH'(prod[i][2]);

      // Stage 3
      o_ycbcr.y  <= scale_clamp(sum[0], 1'b0);
      o_ycbcr.cb <= scale_clamp(sum[1], 1'b1);
      o_ycbcr.cr <= scale_clamp(sum[2], 1'b1);
    end
  end

  a_no_unknown_out: assert property (
    @(posedge video_clk_148) disable iff (video_reset_148)
    !$isunknown(o_ycbcr)
  );

endmodule
`default_nettype wire

//--- design/sync_delay_line.sv
`timescale 1ns/10ps
`default_nettype none
/*
  Delays de, hsync and vsync by DEPTH clocks (DEPTH >= 1).
  All entries clear on reset, so the flags read 0 until refilled.
*/
module sync_delay_line #(
  parameter int DEPTH = 3
) (
  input  logic                   video_clk_148,
  input  logic                   video_reset_148,
  input  video_pkg::video_sync_t i_sync,
  output video_pkg::video_sync_t o_sync
);
  import video_pkg::*;

  video_sync_t sync_sr [DEPTH];

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      for (int i = 0; i < DEPTH; i++)
        sync_sr[i] <= '0;
    end
    else
    begin
      sync_sr[0] <= i_sync;
      for (int i = 1; i < DEPTH; i++)
        sync_sr[i] <= sync_sr[i-1];
    end
  end

  assign o_sync = sync_sr[DEPTH-1];

  // Flags come out exactly DEPTH cycles after they went in
  a_sync_delay: assert property (
    @(posedge video_clk_148) disable iff (video_reset_148)
    !$past(video_reset_148, DEPTH) |-> o_sync == $past(i_sync, DEPTH)
  );

endmodule
`default_nettype wire

//--- design/video_pkg.sv
`default_nettype none
/*
  Shared types and constants of the video output path.
  Colour components are unsigned 8-bit and full range.
  Coefficients are BT.601 weights in units of 1/256.
  Latencies are clock cycles of video_clk_148.
*/
package video_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int COLOR_DEPTH = 8;
  localparam int COMP_MAX    = (1 << COLOR_DEPTH) - 1;
  // Signed product of a zero-extended component and a 9-bit weight
  localparam int PROD_WIDTH  = 18;
  // Sum of three products with headroom
  localparam int SUM_WIDTH   = 20;
  localparam int COEF_SHIFT  = 8;

  ////////////////////////////////////////////////////////////
  // Conversion weights
  ////////////////////////////////////////////////////////////
  localparam int COEF_YR  = 77;
  localparam int COEF_YG  = 150;
  localparam int COEF_YB  = 29;
  localparam int COEF_CBR = -43;
  localparam int COEF_CBG = -85;
  localparam int COEF_CBB = 128;
  localparam int COEF_CRR = 128;
  localparam int COEF_CRG = -107;
  localparam int COEF_CRB = -21;

  localparam int CHROMA_OFFSET = 128;

  // Converter stages, then one more for the packer
  localparam int CONV_LATENCY = 3;
  localparam int OUT_LATENCY  = 4;

  ////////////////////////////////////////////////////////////
  // Pixel and timing bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [COLOR_DEPTH-1:0] r;
    logic [COLOR_DEPTH-1:0] g;
    logic [COLOR_DEPTH-1:0] b;
  } rgb_pixel_t;

  typedef struct packed {
    logic [COLOR_DEPTH-1:0] y;
    logic [COLOR_DEPTH-1:0] cb;
    logic [COLOR_DEPTH-1:0] cr;
  } ycbcr_pixel_t;

  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
  } video_sync_t;

  // Chroma sits in the high byte of the HDMI bus
  typedef struct packed {
    logic [COLOR_DEPTH-1:0] chroma;
    logic [COLOR_DEPTH-1:0] luma;
  } hdmi_word_t;

endpackage
`default_nettype wire

//--- design/video_ycbcr_out.sv
`timescale 1ns/10ps
`default_nettype none
/*
  RGB video in, 16-bit YCbCr 4:2:2 HDMI bus out.
  Free-running stream, one pixel per clock and no back-pressure.
  Outputs lag the inputs by OUT_LATENCY clocks, sync aligned to data.
  video_reset_148 must already be synchronous to video_clk_148.
*/
module video_ycbcr_out (
  input  logic                   video_clk_148,
  input  logic                   video_reset_148,
  input  video_pkg::rgb_pixel_t  i_rgb,
  input  video_pkg::video_sync_t i_sync,
  output logic                   o_hdmi_de,
  output logic                   o_hdmi_hsync,
  output logic                   o_hdmi_vsync,
  output logic [15:0]            o_hdmi_txd
);
  import video_pkg::*;

  ycbcr_pixel_t ycbcr;
  video_sync_t  sync_dly;
  video_sync_t  sync_out;
  hdmi_word_t   word_out;

  ////////////////////////////////////////////////////////////
  // Converter with the sync flags delayed to match it
  ////////////////////////////////////////////////////////////
  rgb_to_ycbcr u_rgb_to_ycbcr (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_rgb           (i_rgb),
    .o_ycbcr         (ycbcr)
  );

  sync_delay_line #(
    .DEPTH (CONV_LATENCY)
  ) u_sync_delay_line (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_sync          (i_sync),
    .o_sync          (sync_dly)
  );

  ycbcr422_packer u_ycbcr422_packer (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_ycbcr         (ycbcr),
    .i_sync          (sync_dly),
    .o_sync          (sync_out),
    .o_word          (word_out)
  );

  // HDMI pins
  assign o_hdmi_de    = sync_out.de;
  assign o_hdmi_hsync = sync_out.hs;
  assign o_hdmi_vsync = sync_out.vs;
  assign o_hdmi_txd   = word_out;

endmodule
`default_nettype wire

//--- design/ycbcr422_packer.sv
`timescale 1ns/10ps
`default_nettype none
/*
  4:2:2 packer. Y goes in the low byte, Cb and Cr alternate in the high
  byte, starting with Cb on the first pixel of every de run.
  Chroma is not averaged. Each pixel keeps its own Cb or Cr.
  The word is forced to 0 while de is low.
*/
module ycbcr422_packer (
  input  logic                    video_clk_148,
  input  logic                    video_reset_148,
  input  video_pkg::ycbcr_pixel_t i_ycbcr,
  input  video_pkg::video_sync_t  i_sync,
  output video_pkg::video_sync_t  o_sync,
  output video_pkg::hdmi_word_t   o_word
);
  import video_pkg::*;

  // High selects Cr for the current pixel
  logic       cr_phase;
  hdmi_word_t word_next;

  always_comb
  begin
    word_next = '0;
    if (i_sync.de)
    begin
      word_next.luma   = i_ycbcr.y;
      word_next.chroma = cr_phase ? i_ycbcr.cr : i_ycbcr.cb;
    end
  end

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      cr_phase <= 1'b0;
      o_sync   <= '0;
      o_word   <= '0;
    end
    else
    begin
      // Toggle on active pixels and return to Cb in blanking
      if (i_sync.de)
        cr_phase <= ~cr_phase;
      else
        cr_phase <= 1'b0;
      o_sync <= i_sync;
      o_word <= word_next;
    end
  end

  // First pixel of a run leaves with its Cb in the chroma byte
  a_run_starts_cb: assert property (
    @(posedge video_clk_148) disable iff (video_reset_148)
    $rose(i_sync.de) |=> o_word.chroma == $past(i_ycbcr.cb)
  );

endmodule
`default_nettype wire

//--- verif/ycbcr_model.svh
/*
  Reference model of the RGB to YCbCr conversion and of the 4:2:2
  chroma phase. It is included inside the testbench module after the
  video_pkg import. Results are floored, then clamped to 0..255.
*/
`ifndef YCBCR_MODEL_SVH
`define YCBCR_MODEL_SVH

// One component: weighted sum, floor of /256, optional offset, clamp
function automatic logic [COLOR_DEPTH-1:0] model_component(
  input rgb_pixel_t px,
  input int         wr,
  input int         wg,
  input int         wb,
  input int         offset
);
  int acc;
  acc = int'(px.r) * wr + int'(px.g) * wg + int'(px.b) * wb;
  acc = (acc >>> 8) + offset;
  if (acc < 0)
    acc = 0;
  else if (acc > 255)
    acc = 255;
  return acc[COLOR_DEPTH-1:0];
endfunction

function automatic ycbcr_pixel_t model_pixel(input rgb_pixel_t px);
  ycbcr_pixel_t c;
  c.y  = model_component(px, COEF_YR, COEF_YG, COEF_YB, 0);
  c.cb = model_component(px, COEF_CBR, COEF_CBG, COEF_CBB, CHROMA_OFFSET);
  c.cr = model_component(px, COEF_CRR, COEF_CRG, COEF_CRB, CHROMA_OFFSET);
  return c;
endfunction

// Word on the bus, zero in blanking
function automatic hdmi_word_t model_word(
  input ycbcr_pixel_t c,
  input logic         de,
  input logic         cr_sel
);
  hdmi_word_t w;
  w = '0;
  if (de)
  begin
    w.luma   = c.y;
    w.chroma = cr_sel ? c.cr : c.cb;
  end
  return w;
endfunction

// Alternate inside a run, back to Cb in blanking
function automatic logic model_next_phase(input logic de, input logic cr_sel);
  return de ? ~cr_sel : 1'b0;
endfunction

`endif

//--- verif/tb_video_ycbcr_out.sv
`timescale 1ns/10ps
`default_nettype none
/*
  Directed testbench for video_ycbcr_out.
  Inputs change 1 ns after the rising edge. Every driven pixel is checked
  OUT_LATENCY clocks later against the model. The run stops at the first error.
*/
module tb_video_ycbcr_out;
  import video_pkg::*;

  `include "ycbcr_model.svh"

  localparam int RESET_TIMEOUT = 40;
  localparam int DRAIN_TIMEOUT = 32;
  localparam video_sync_t ACTIVE = '{de: 1'b1, hs: 1'b0, vs: 1'b0};

  logic        video_clk_148;
  logic        video_reset_148 = 1'b1;
  rgb_pixel_t  rgb_in;
  video_sync_t sync_in;
  logic        o_hdmi_de;
  logic        o_hdmi_hsync;
  logic        o_hdmi_vsync;
  logic [15:0] o_hdmi_txd;

  // Expected output of each driven pixel, oldest first
  hdmi_word_t  exp_word_q [$];
  video_sync_t exp_sync_q [$];
  logic        cr_sel;

  video_ycbcr_out dut_i (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_rgb           (rgb_in),
    .i_sync          (sync_in),
    .o_hdmi_de       (o_hdmi_de),
    .o_hdmi_hsync    (o_hdmi_hsync),
    .o_hdmi_vsync    (o_hdmi_vsync),
    .o_hdmi_txd      (o_hdmi_txd)
  );

  initial
  begin
    video_clk_148 = 1'b0;
    forever #50 video_clk_148 = ~video_clk_148;
  end

  initial
  begin
    repeat (16) @(posedge video_clk_148);
    #1 video_reset_148 = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic check_word(input string name, input hdmi_word_t got, input hdmi_word_t exp);
    if (got !== exp)
      report_failure($sformatf("Error at %0t: %s got %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_sync(input string name, input video_sync_t got, input video_sync_t exp);
    if (got !== exp)
      report_failure($sformatf("Error at %0t: %s got %b, expected %b", $time, name, got, exp));
  endtask

  function automatic video_sync_t out_sync();
    video_sync_t s;
    s.de = o_hdmi_de;
    s.hs = o_hdmi_hsync;
    s.vs = o_hdmi_vsync;
    return s;
  endfunction

  task automatic check_outputs(input hdmi_word_t exp_w, input video_sync_t exp_s);
    check_word("o_hdmi_txd", hdmi_word_t'(o_hdmi_txd), exp_w);
    check_sync("{o_hdmi_de,o_hdmi_hsync,o_hdmi_vsync}", out_sync(), exp_s);
  endtask

  // Check the pixel from OUT_LATENCY clocks ago, then drive the next one
  task automatic step(input rgb_pixel_t px, input video_sync_t sy);
    @(posedge video_clk_148);
    #1;
    if (exp_word_q.size() == OUT_LATENCY)
      check_outputs(exp_word_q.pop_front(), exp_sync_q.pop_front());
    rgb_in  = px;
    sync_in = sy;
    exp_word_q.push_back(model_word(model_pixel(px), sy.de, cr_sel));
    exp_sync_q.push_back(sy);
    cr_sel = model_next_phase(sy.de, cr_sel);
  endtask

  function automatic int pending_active();
    int n;
    n = 0;
    foreach (exp_word_q[i])
      if (exp_word_q[i] != '0 || exp_sync_q[i] != '0)
        n++;
    return n;
  endfunction

  task automatic drain();
    int cycles;
    cycles = 0;
    while (pending_active() > 0)
    begin
      step('0, '0);
      cycles++;
      if (cycles > DRAIN_TIMEOUT)
        report_failure("The pipeline did not drain within the timeout");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset();
    int cycles;
    cycles = 0;
    while (video_reset_148)
    begin
      @(negedge video_clk_148);
      check_outputs('0, '0);
      cycles++;
      if (cycles > RESET_TIMEOUT)
        report_failure("Reset was never released");
    end
    // Blank inputs flushing through the cleared pipeline
    repeat (2 * OUT_LATENCY)
    begin
      step('0, '0);
      check_outputs('0, '0);
    end
  endtask

  task automatic test_fixed_colors();
    rgb_pixel_t colors [5];
    colors = '{24'h000000, 24'hffffff, 24'hff0000, 24'h00ff00, 24'h0000ff};
    foreach (colors[i])
      step(colors[i], ACTIVE);
    drain();
  endtask

  task automatic test_chroma_phase();
    int runs [3];
    int gaps [3];
    int n;
    runs = '{5, 4, 1};
    gaps = '{2, 1, 3};
    n = 0;
    for (int r = 0; r < 3; r++)
    begin
      for (int i = 0; i < runs[r]; i++)
      begin
        step({8'(n * 17), 8'(255 - n * 9), 8'(n * 31)}, ACTIVE);
        n++;
      end
      repeat (gaps[r]) step('0, '0);
    end
    drain();
  endtask

  task automatic test_sync_alignment();
    video_sync_t sy;
    for (int i = 0; i < 48; i++)
    begin
      sy.hs = (i == 2) || (i >= 10 && i < 13) || (i >= 20 && i < 27);
      sy.vs = (i >= 5 && i < 7) || (i >= 30 && i < 35);
      sy.de = (i == 8) || (i >= 14 && i < 19) || (i >= 36 && i < 46);
      step(24'($urandom()), sy);
    end
    drain();
  endtask

  task automatic test_random_line();
    repeat (64) step(24'($urandom()), ACTIVE);
    repeat (8) step('0, '0);
    drain();
  endtask

  initial
  begin
    void'($urandom(32'h856391c7));
    rgb_in  = '0;
    sync_in = '0;
    cr_sel  = 1'b0;
    test_reset();
    test_fixed_colors();
    test_chroma_phase();
    test_sync_alignment();
    test_random_line();
    $display("All tests passed");
    $finish;
  end

endmodule
`default_nettype wire

//--- video_ycbcr_out.f
+incdir+verif
design/video_pkg.sv
design/rgb_to_ycbcr.sv
design/sync_delay_line.sv
design/ycbcr422_packer.sv
design/video_ycbcr_out.sv
verif/tb_video_ycbcr_out.sv
